/* logic/user_io_pkg.sv */
package user_io_pkg;

	// bit counter positions
	// bits 0..7 carry the command, payload bytes run 8..15 and wrap
	localparam logic [3:0] BIT_CMD_LAST     = 4'd7;
	localparam logic [3:0] BIT_CLEAR        = 4'd9;
	localparam logic [3:0] BIT_PAYLOAD_LAST = 4'd15;

	// command opcodes sent by the io controller as the first byte of a frame
	typedef enum logic [7:0] {
		CMD_BUT_SW       = 8'h01,
		CMD_IKBD_IN      = 8'h02,
		CMD_IKBD_OUT     = 8'h03,
		CMD_SERIAL_IN    = 8'h04,
		CMD_SERIAL_OUT   = 8'h05,
		CMD_PARALLEL_OUT = 8'h06,
		CMD_MIDI_OUT     = 8'h08,
		CMD_MAC          = 8'h09,
		CMD_ETH_STATUS   = 8'h0a,
		CMD_ETH_TX_READ  = 8'h0b,
		CMD_ETH_RX_WRITE = 8'h0c,
		CMD_JOY0         = 8'h10,
		CMD_JOY1         = 8'h11,
		CMD_JOY2         = 8'h12,
		CMD_JOY3         = 8'h13
	} io_cmd_e;

	// per-edge frame event, valid only in the posedge it is flagged
	typedef struct packed {
		logic       cmd_done;
		logic       byte_done;
		// payload byte index bit 0, even bytes are flags, odd bytes data
		logic       odd_byte;
		logic [7:0] data;
		io_cmd_e    cmd;
	} spi_rx_t;

	// position inside the frame, used for miso selection and strobe clearing
	typedef struct packed {
		logic [3:0] bit_cnt;
		logic [1:0] byte_cnt;
	} spi_pos_t;

	// byte from the io controller into the core
	typedef struct packed {
		logic       strobe;
		logic [7:0] data;
	} chan_in_t;

	// byte from the core towards the io controller
	typedef struct packed {
		logic       available;
		logic [7:0] data;
	} chan_out_t;

endpackage

/* logic/spi_frame.sv */
`timescale 1ns/1ps

module spi_frame (
	input  logic                 spi_sck,
	input  logic                 SPI_SS_IO,
	input  logic                 spi_mosi,
	output user_io_pkg::spi_rx_t  rx,
	output user_io_pkg::spi_pos_t pos
);

	logic [3:0] bit_cnt;
	logic [1:0] byte_cnt;
	logic [6:0] sbuf;
	user_io_pkg::io_cmd_e cmd;
	logic [7:0] rx_byte;

	// byte completing at this edge, the live mosi bit is its lsb
	assign rx_byte = {sbuf, spi_mosi};

	// counter runs 0..7 then 8..15 repeatedly, byte_cnt steps on every wrap
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt  <= 4'd0;
			byte_cnt <= 2'd0;
		end else begin
			if (bit_cnt == user_io_pkg::BIT_PAYLOAD_LAST) begin
				bit_cnt  <= user_io_pkg::BIT_CMD_LAST + 4'd1;
				byte_cnt <= byte_cnt + 2'd1;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// msb first shift register
	always_ff @(posedge spi_sck) begin
		sbuf <= {sbuf[5:0], spi_mosi};
	end

	// command stays latched until the next frame's command byte
	always_ff @(posedge spi_sck) begin
		if (bit_cnt == user_io_pkg::BIT_CMD_LAST) begin
			cmd <= user_io_pkg::io_cmd_e'(rx_byte);
		end
	end

	always_comb begin
		rx.cmd_done  = (bit_cnt == user_io_pkg::BIT_CMD_LAST);
		rx.byte_done = (bit_cnt == user_io_pkg::BIT_PAYLOAD_LAST);
		rx.odd_byte  = byte_cnt[0];
		rx.data      = rx_byte;
		rx.cmd       = cmd;
	end

	assign pos.bit_cnt  = bit_cnt;
	assign pos.byte_cnt = byte_cnt;

endmodule

/* logic/io_cmd_decode.sv */
`timescale 1ns/1ps

module io_cmd_decode (
	input  logic                  spi_sck,
	input  logic                  SPI_SS_IO,
	input  user_io_pkg::spi_rx_t  rx,
	input  user_io_pkg::spi_pos_t pos,
	output logic [1:0]            buttons,
	output logic [1:0]            switches,
	output logic                  scandoubler_disable,
	output logic [5:0]            joy0,
	output logic [5:0]            joy1,
	output logic [5:0]            joy2,
	output logic [5:0]            joy3,
	output user_io_pkg::chan_in_t ikbd_in,
	output user_io_pkg::chan_in_t serial_in,
	output logic                  ikbd_strobe_out,
	output logic                  serial_strobe_out,
	output logic                  parallel_strobe_out,
	output logic                  midi_strobe_out,
	output logic                  eth_mac_begin,
	output logic                  eth_mac_strobe,
	output logic [7:0]            eth_mac_byte,
	output logic                  eth_tx_read_begin,
	output logic                  eth_tx_read_strobe,
	output logic                  eth_rx_write_begin,
	output logic                  eth_rx_write_strobe,
	output logic [7:0]            eth_rx_write_byte
);

	logic [4:0] but_sw;
	logic       ikbd_strobe_in;
	logic       serial_strobe_in;
	logic [7:0] ikbd_data_in;
	logic [7:0] serial_data_in;
	logic       clear_strobes;

	assign buttons             = but_sw[1:0];
	assign switches            = but_sw[3:2];
	assign scandoubler_disable = but_sw[4];

	assign ikbd_in   = '{strobe: ikbd_strobe_in, data: ikbd_data_in};
	assign serial_in = '{strobe: serial_strobe_in, data: serial_data_in};

	// strobes drop two clocks after they rise
	assign clear_strobes = (pos.bit_cnt == user_io_pkg::BIT_CLEAR);

	// handshake flags, all cleared when the frame ends
	always_ff @(posedge spi_sck or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			ikbd_strobe_in      <= 1'b0;
			serial_strobe_in    <= 1'b0;
			ikbd_strobe_out     <= 1'b0;
			serial_strobe_out   <= 1'b0;
			parallel_strobe_out <= 1'b0;
			midi_strobe_out     <= 1'b0;
			eth_mac_begin       <= 1'b0;
			eth_mac_strobe      <= 1'b0;
			eth_tx_read_begin   <= 1'b0;
			eth_tx_read_strobe  <= 1'b0;
			eth_rx_write_begin  <= 1'b0;
			eth_rx_write_strobe <= 1'b0;
		end else begin
			if (clear_strobes) begin
				ikbd_strobe_in      <= 1'b0;
				serial_strobe_in    <= 1'b0;
				ikbd_strobe_out     <= 1'b0;
				serial_strobe_out   <= 1'b0;
				parallel_strobe_out <= 1'b0;
				midi_strobe_out     <= 1'b0;
				eth_mac_strobe      <= 1'b0;
				eth_tx_read_strobe  <= 1'b0;
				eth_rx_write_strobe <= 1'b0;
			end

			// command byte just arrived, rx.cmd still holds the previous one
			if (rx.cmd_done) begin
				case (user_io_pkg::io_cmd_e'(rx.data))
					user_io_pkg::CMD_MAC: eth_mac_begin <= 1'b1;
					user_io_pkg::CMD_ETH_TX_READ: begin
						eth_tx_read_begin  <= 1'b1;
						// first tx byte must be fetched before it is shifted out
						eth_tx_read_strobe <= 1'b1;
					end
					user_io_pkg::CMD_ETH_RX_WRITE: eth_rx_write_begin <= 1'b1;
					default: ;
				endcase
			end

			if (rx.byte_done) begin
				eth_mac_begin <= 1'b0;
				case (rx.cmd)
					user_io_pkg::CMD_IKBD_IN:      ikbd_strobe_in <= 1'b1;
					user_io_pkg::CMD_SERIAL_IN:    serial_strobe_in <= 1'b1;
					// outbound reads advance only after the data byte
					user_io_pkg::CMD_IKBD_OUT:     ikbd_strobe_out <= rx.odd_byte;
					user_io_pkg::CMD_SERIAL_OUT:   serial_strobe_out <= rx.odd_byte;
					user_io_pkg::CMD_PARALLEL_OUT: parallel_strobe_out <= rx.odd_byte;
					user_io_pkg::CMD_MIDI_OUT:     midi_strobe_out <= rx.odd_byte;
					user_io_pkg::CMD_MAC:          eth_mac_strobe <= 1'b1;
					user_io_pkg::CMD_ETH_TX_READ:  eth_tx_read_strobe <= 1'b1;
					user_io_pkg::CMD_ETH_RX_WRITE: eth_rx_write_strobe <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	// data and config registers survive between frames
	always_ff @(posedge spi_sck) begin
		if (rx.byte_done) begin
			case (rx.cmd)
				user_io_pkg::CMD_BUT_SW:       but_sw <= rx.data[4:0];
				user_io_pkg::CMD_IKBD_IN:      ikbd_data_in <= rx.data;
				user_io_pkg::CMD_SERIAL_IN:    serial_data_in <= rx.data;
				user_io_pkg::CMD_MAC:          eth_mac_byte <= rx.data;
				user_io_pkg::CMD_ETH_RX_WRITE: eth_rx_write_byte <= rx.data;
				user_io_pkg::CMD_JOY0:         joy0 <= rx.data[5:0];
				user_io_pkg::CMD_JOY1:         joy1 <= rx.data[5:0];
				user_io_pkg::CMD_JOY2:         joy2 <= rx.data[5:0];
				user_io_pkg::CMD_JOY3:         joy3 <= rx.data[5:0];
				default: ;
			endcase
		end
	end

endmodule

/* logic/miso_select.sv */
`timescale 1ns/1ps

module miso_select (
	input  logic                   spi_sck,
	input  user_io_pkg::spi_pos_t  pos,
	input  user_io_pkg::io_cmd_e   cmd,
	input  logic [7:0]             core_type,
	input  user_io_pkg::chan_out_t ikbd_out,
	input  user_io_pkg::chan_out_t serial_out,
	input  user_io_pkg::chan_out_t parallel_out,
	input  user_io_pkg::chan_out_t midi_out,
	input  logic [31:0]            eth_status,
	input  logic [7:0]             eth_tx_read_byte,
	output logic                   spi_miso
);

	logic [2:0] tx_bit;
	logic       next_bit;

	// bit index within the current byte, msb first
	assign tx_bit = ~pos.bit_cnt[2:0];

	// even bytes carry the available flag in the lsb, odd bytes the data
	function automatic logic chan_bit(
		input user_io_pkg::chan_out_t ch,
		input logic                   odd,
		input logic [2:0]             idx
	);
		logic b;
		if (odd) begin
			b = ch.data[idx];
		end else begin
			b = (idx == 3'd0) ? ch.available : 1'b0;
		end
		return b;
	endfunction

	always_comb begin
		next_bit = 1'b0;
		if (pos.bit_cnt <= user_io_pkg::BIT_CMD_LAST) begin
			next_bit = core_type[tx_bit];
		end else begin
			case (cmd)
				user_io_pkg::CMD_IKBD_OUT:
					next_bit = chan_bit(ikbd_out, pos.byte_cnt[0], tx_bit);
				user_io_pkg::CMD_SERIAL_OUT:
					next_bit = chan_bit(serial_out, pos.byte_cnt[0], tx_bit);
				user_io_pkg::CMD_PARALLEL_OUT:
					next_bit = chan_bit(parallel_out, pos.byte_cnt[0], tx_bit);
				user_io_pkg::CMD_MIDI_OUT:
					next_bit = chan_bit(midi_out, pos.byte_cnt[0], tx_bit);
				// byte 0 is the top byte of the status word
				user_io_pkg::CMD_ETH_STATUS:
					next_bit = eth_status[{~pos.byte_cnt, tx_bit}];
				user_io_pkg::CMD_ETH_TX_READ:
					next_bit = eth_tx_read_byte[tx_bit];
				default: next_bit = 1'b0;
			endcase
		end
	end

	// launched on the falling edge so the master samples a stable bit
	always_ff @(negedge spi_sck) begin
		spi_miso <= next_bit;
	end

endmodule

/* logic/user_io.sv */
`timescale 1ns/1ps

module user_io (
	input  logic                   spi_sck,
	input  logic                   SPI_SS_IO,
	input  logic                   spi_mosi,
	output logic                   spi_miso,
	input  logic [7:0]             core_type,
	output user_io_pkg::chan_in_t  ikbd_in,
	output user_io_pkg::chan_in_t  serial_in,
	input  user_io_pkg::chan_out_t ikbd_out,
	input  user_io_pkg::chan_out_t serial_out,
	input  user_io_pkg::chan_out_t parallel_out,
	input  user_io_pkg::chan_out_t midi_out,
	output logic                   ikbd_strobe_out,
	output logic                   serial_strobe_out,
	output logic                   parallel_strobe_out,
	output logic                   midi_strobe_out,
	output logic [5:0]             joy0,
	output logic [5:0]             joy1,
	output logic [5:0]             joy2,
	output logic [5:0]             joy3,
	input  logic [31:0]            eth_status,
	output logic                   eth_mac_begin,
	output logic                   eth_mac_strobe,
	output logic [7:0]             eth_mac_byte,
	output logic                   eth_tx_read_begin,
	output logic                   eth_tx_read_strobe,
	input  logic [7:0]             eth_tx_read_byte,
	output logic                   eth_rx_write_begin,
	output logic                   eth_rx_write_strobe,
	output logic [7:0]             eth_rx_write_byte,
	output logic [1:0]             buttons,
	output logic [1:0]             switches,
	output logic                   scandoubler_disable
);

	user_io_pkg::spi_rx_t  rx;
	user_io_pkg::spi_pos_t pos;

	spi_frame u_frame (
		.spi_sck   (spi_sck),
		.SPI_SS_IO (SPI_SS_IO),
		.spi_mosi  (spi_mosi),
		.rx        (rx),
		.pos       (pos)
	);

	io_cmd_decode u_decode (
		.spi_sck             (spi_sck),
		.SPI_SS_IO           (SPI_SS_IO),
		.rx                  (rx),
		.pos                 (pos),
		.buttons             (buttons),
		.switches            (switches),
		.scandoubler_disable (scandoubler_disable),
		.joy0                (joy0),
		.joy1                (joy1),
		.joy2                (joy2),
		.joy3                (joy3),
		.ikbd_in             (ikbd_in),
		.serial_in           (serial_in),
		.ikbd_strobe_out     (ikbd_strobe_out),
		.serial_strobe_out   (serial_strobe_out),
		.parallel_strobe_out (parallel_strobe_out),
		.midi_strobe_out     (midi_strobe_out),
		.eth_mac_begin       (eth_mac_begin),
		.eth_mac_strobe      (eth_mac_strobe),
		.eth_mac_byte        (eth_mac_byte),
		.eth_tx_read_begin   (eth_tx_read_begin),
		.eth_tx_read_strobe  (eth_tx_read_strobe),
		.eth_rx_write_begin  (eth_rx_write_begin),
		.eth_rx_write_strobe (eth_rx_write_strobe),
		.eth_rx_write_byte   (eth_rx_write_byte)
	);

	// latched command travels inside the frame event
	miso_select u_miso (
		.spi_sck          (spi_sck),
		.pos              (pos),
		.cmd              (rx.cmd),
		.core_type        (core_type),
		.ikbd_out         (ikbd_out),
		.serial_out       (serial_out),
		.parallel_out     (parallel_out),
		.midi_out         (midi_out),
		.eth_status       (eth_status),
		.eth_tx_read_byte (eth_tx_read_byte),
		.spi_miso         (spi_miso)
	);

endmodule

/* verif/user_io_chk.sv */
`timescale 1ns/1ps

module user_io_chk (
	input logic                 spi_sck,
	input logic                 SPI_SS_IO,
	input user_io_pkg::spi_rx_t rx,
	input logic [8:0]           strobes,
	input logic                 eth_mac_begin
);

	// handshake outputs stay low while no frame is active
	a_idle_quiet: assert property (@(posedge spi_sck)
		SPI_SS_IO && $past(SPI_SS_IO) |-> (strobes == '0) && !eth_mac_begin)
		else $error("strobe or eth_mac_begin high while SPI_SS_IO is high");

	a_mac_begin: assert property (@(posedge spi_sck)
		eth_mac_begin |-> rx.cmd == user_io_pkg::CMD_MAC)
		else $error("eth_mac_begin high outside a MAC frame");

	// a strobe lasts two clocks at most, or ends early with the frame
	for (genvar i = 0; i < 9; i++) begin : g_fall
		a_strobe_fall: assert property (@(posedge spi_sck)
			$rose(strobes[i]) |-> ##[1:3] !strobes[i])
			else $error("strobe bit %0d did not fall within three cycles", i);
	end

endmodule

bind io_cmd_decode user_io_chk u_chk (
	.spi_sck       (spi_sck),
	.SPI_SS_IO     (SPI_SS_IO),
	.rx            (rx),
	.strobes       ({ikbd_in.strobe, serial_in.strobe, ikbd_strobe_out, serial_strobe_out,
		parallel_strobe_out, midi_strobe_out, eth_mac_strobe, eth_tx_read_strobe,
		eth_rx_write_strobe}),
	.eth_mac_begin (eth_mac_begin)
);

/* verif/user_io_tb.sv */
`timescale 1ns/1ps

module user_io_tb;

	logic spi_sck;
	logic SPI_SS_IO;
	logic spi_mosi;
	logic spi_miso;
	logic [7:0] core_type;
	user_io_pkg::chan_in_t ikbd_in;
	user_io_pkg::chan_in_t serial_in;
	user_io_pkg::chan_out_t ikbd_out;
	user_io_pkg::chan_out_t serial_out;
	user_io_pkg::chan_out_t parallel_out;
	user_io_pkg::chan_out_t midi_out;
	logic ikbd_strobe_out;
	logic serial_strobe_out;
	logic parallel_strobe_out;
	logic midi_strobe_out;
	logic [5:0] joy0;
	logic [5:0] joy1;
	logic [5:0] joy2;
	logic [5:0] joy3;
	logic [31:0] eth_status;
	logic eth_mac_begin;
	logic eth_mac_strobe;
	logic [7:0] eth_mac_byte;
	logic eth_tx_read_begin;
	logic eth_tx_read_strobe;
	logic [7:0] eth_tx_read_byte;
	logic eth_rx_write_begin;
	logic eth_rx_write_strobe;
	logic [7:0] eth_rx_write_byte;
	logic [1:0] buttons;
	logic [1:0] switches;
	logic scandoubler_disable;

	// 11 words per vector line
	logic [31:0] vec [0:1023];
	user_io_pkg::io_cmd_e cur_cmd;
	int sel_idx = -1;
	int strobe_rises;
	int sel_rises;
	int begin_rises;
	int cmd_begin_rises;
	// bits shifted so far in the current frame, command bits included
	int bits_sent;
	int last_rise_bits;
	logic [7:0] in_bytes [$];
	logic [8:0] strobe_prev;
	logic [2:0] begin_prev;
	logic [8:0] strobes_now;
	logic [23:0] joy_exp = 'x;
	logic [4:0] sw_exp = 'x;
	string strobe_names [0:8] = '{"eth_rx_write_strobe", "eth_tx_read_strobe",
		"eth_mac_strobe", "midi_strobe_out", "parallel_strobe_out", "serial_strobe_out",
		"ikbd_strobe_out", "serial_in.strobe", "ikbd_in.strobe"};

	assign strobes_now = {ikbd_in.strobe, serial_in.strobe, ikbd_strobe_out, serial_strobe_out,
		parallel_strobe_out, midi_strobe_out, eth_mac_strobe, eth_tx_read_strobe,
		eth_rx_write_strobe};

	user_io dut (.*);

	initial begin
		spi_sck = 1'b0;
		forever #5 spi_sck = ~spi_sck;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			report_failure($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, expected));
		end
	endtask

	function automatic int strobe_index(input user_io_pkg::io_cmd_e cmd);
		case (cmd)
			user_io_pkg::CMD_IKBD_IN:      return 8;
			user_io_pkg::CMD_SERIAL_IN:    return 7;
			user_io_pkg::CMD_IKBD_OUT:     return 6;
			user_io_pkg::CMD_SERIAL_OUT:   return 5;
			user_io_pkg::CMD_PARALLEL_OUT: return 4;
			user_io_pkg::CMD_MIDI_OUT:     return 3;
			user_io_pkg::CMD_MAC:          return 2;
			user_io_pkg::CMD_ETH_TX_READ:  return 1;
			user_io_pkg::CMD_ETH_RX_WRITE: return 0;
			default: return -1;
		endcase
	endfunction

	// byte the io controller should see for payload byte k
	function automatic logic [7:0] expected_read(input user_io_pkg::io_cmd_e cmd, input int k,
		input logic avail, input logic [7:0] data, input logic [31:0] status);
		case (cmd)
			user_io_pkg::CMD_IKBD_OUT, user_io_pkg::CMD_SERIAL_OUT,
			user_io_pkg::CMD_PARALLEL_OUT, user_io_pkg::CMD_MIDI_OUT:
				return (k % 2) ? data : {7'd0, avail};
			user_io_pkg::CMD_ETH_STATUS: return status[31 - 8 * (k % 4) -: 8];
			user_io_pkg::CMD_ETH_TX_READ: return data;
			default: return 8'h00;
		endcase
	endfunction

	// strobes and begin flags are sampled half a clock after they move
	always @(negedge spi_sck) begin : monitor
		logic [8:0] rises;
		logic [2:0] begins_now;
		logic [2:0] begin_up;
		begins_now = {eth_mac_begin, eth_tx_read_begin, eth_rx_write_begin};
		rises = strobes_now & ~strobe_prev;
		begin_up = begins_now & ~begin_prev;
		strobe_rises += $countones(rises);
		begin_rises += $countones(begin_up);
		strobe_prev = strobes_now;
		begin_prev = begins_now;
		// begin flags share the low strobe indices of their commands
		if (sel_idx >= 0 && sel_idx < 3 && begin_up[sel_idx] === 1'b1) begin
			cmd_begin_rises++;
		end
		if (sel_idx >= 0 && rises[sel_idx] === 1'b1) begin
			sel_rises++;
			last_rise_bits = bits_sent;
			case (cur_cmd)
				user_io_pkg::CMD_IKBD_IN:      in_bytes.push_back(ikbd_in.data);
				user_io_pkg::CMD_SERIAL_IN:    in_bytes.push_back(serial_in.data);
				user_io_pkg::CMD_MAC:          in_bytes.push_back(eth_mac_byte);
				user_io_pkg::CMD_ETH_RX_WRITE: in_bytes.push_back(eth_rx_write_byte);
				default: ;
			endcase
		end
	end

	// called on a falling edge, returns on a falling edge
	task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
		for (int i = 7; i >= 0; i--) begin
			spi_mosi = tx[i];
			@(posedge spi_sck);
			bits_sent++;
			rx[i] = spi_miso;
			@(negedge spi_sck);
		end
	endtask

	task automatic wait_strobes(input int expected);
		int cycles;
		cycles = 0;
		do begin
			@(posedge spi_sck);
			cycles++;
		end while (sel_rises < expected && cycles < 40);
		if (sel_rises < expected) begin
			report_failure($sformatf("%s never rose for frame command 0x%0h",
				strobe_names[sel_idx], cur_cmd));
		end
	endtask

	task automatic run_frame(input int v);
		logic [31:0] f [0:10];
		logic [7:0] got;
		logic [7:0] data;
		logic [31:0] status;
		logic avail;
		user_io_pkg::io_cmd_e cmd;
		user_io_pkg::chan_out_t mine;
		user_io_pkg::chan_out_t other;
		for (int i = 0; i < 11; i++) begin
			f[i] = vec[11 * v + i];
		end
		cmd = user_io_pkg::io_cmd_e'(f[0][7:0]);
		core_type = f[3][0] ? 8'($urandom) : f[4][7:0];
		data = f[3][1] ? 8'($urandom) : f[6][7:0];
		status = f[3][1] ? $urandom : f[7];
		avail = f[5][0];
		// unaddressed channels carry inverted values so a wrong select shows
		mine = '{available: avail, data: data};
		other = '{available: ~avail, data: ~data};
		ikbd_out = (cmd == user_io_pkg::CMD_IKBD_OUT) ? mine : other;
		serial_out = (cmd == user_io_pkg::CMD_SERIAL_OUT) ? mine : other;
		parallel_out = (cmd == user_io_pkg::CMD_PARALLEL_OUT) ? mine : other;
		midi_out = (cmd == user_io_pkg::CMD_MIDI_OUT) ? mine : other;
		eth_status = status;
		eth_tx_read_byte = data;
		cur_cmd = cmd;
		sel_idx = strobe_index(cmd);
		strobe_rises = 0;
		sel_rises = 0;
		begin_rises = 0;
		cmd_begin_rises = 0;
		bits_sent = 0;
		last_rise_bits = 0;
		in_bytes.delete();
		@(negedge spi_sck);
		SPI_SS_IO = 1'b0;
		shift_byte(f[0][7:0], got);
		check_value("spi_miso command byte", got, core_type);
		for (int k = 0; k < f[1]; k++) begin
			shift_byte(f[2][31 - 8 * k -: 8], got);
			check_value($sformatf("spi_miso payload byte %0d", k), got,
				expected_read(cmd, k, avail, data, status));
		end
		wait_strobes(f[8]);
		@(negedge spi_sck);
		SPI_SS_IO = 1'b1;
		check_value("strobe rises", strobe_rises, f[8]);
		check_value("command strobe rises", sel_rises, f[8]);
		check_value("begin rises", begin_rises, f[9]);
		check_value("command begin rises", cmd_begin_rises, f[9]);
		// the last strobe of a frame follows its last payload byte
		if (f[8] != 0) begin
			check_value("last strobe bit position", last_rise_bits, 8 * (f[1] + 1));
		end
		for (int k = 0; k < in_bytes.size(); k++) begin
			check_value($sformatf("strobed byte %0d", k), in_bytes[k], f[2][31 - 8 * k -: 8]);
		end
		if (cmd == user_io_pkg::CMD_BUT_SW) begin
			sw_exp = f[10][4:0];
		end
		if (cmd inside {[user_io_pkg::CMD_JOY0 : user_io_pkg::CMD_JOY3]}) begin
			joy_exp[6 * cmd[1:0] +: 6] = f[10][5:0];
		end
		// registers not yet written are still unknown on both sides
		check_value("buttons_switches", {scandoubler_disable, switches, buttons}, sw_exp);
		check_value("joysticks", {joy3, joy2, joy1, joy0}, joy_exp);
	endtask

	initial begin
		int v;
		void'($urandom(32'h7fe51cde));
		SPI_SS_IO = 1'b1;
		spi_mosi = 1'b0;
		core_type = 8'h00;
		ikbd_out = '0;
		serial_out = '0;
		parallel_out = '0;
		midi_out = '0;
		eth_status = 32'h0;
		eth_tx_read_byte = 8'h00;
		$readmemh("verif/user_io_vectors.txt", vec);
		repeat (4) @(negedge spi_sck);
		for (v = 0; v < 93 && !$isunknown(vec[11 * v]); v++) begin
			run_frame(v);
		end
		if (v == 0) begin
			report_failure("no vectors were read from verif/user_io_vectors.txt");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

/* files.f */
logic/user_io_pkg.sv
logic/spi_frame.sv
logic/io_cmd_decode.sv
logic/miso_select.sv
logic/user_io.sv
verif/user_io_chk.sv
verif/user_io_tb.sv

/* verif/user_io_vectors.txt */
// cmd nbytes payload(byte0 in msb) rand(bit0 core_type, bit1 data and status) core_type
// avail data eth_status exp_strobes exp_begins exp_reg
01 1 15000000 0 a5 0 00 00000000 0 0 15
10 1 2a000000 1 00 0 00 00000000 0 0 2a
11 1 ff000000 0 3c 0 00 00000000 0 0 3f
12 1 c5000000 0 5a 0 00 00000000 0 0 05
13 1 1e000000 1 00 0 00 00000000 0 0 1e
02 3 a1b2c300 0 c3 0 00 00000000 3 0 00
04 2 5a7e0000 0 81 0 00 00000000 2 0 00
03 2 00000000 2 7e 1 00 00000000 1 0 00
05 2 00000000 0 66 0 81 00000000 1 0 00
06 2 00000000 0 99 1 3c 00000000 1 0 00
08 2 00000000 3 00 0 00 00000000 1 0 00
0a 4 00000000 0 e7 0 00 12345678 0 0 00
0a 4 00000000 2 18 0 00 00000000 0 0 00
09 4 0002f7c1 0 42 0 00 00000000 4 1 00
0b 3 00000000 0 24 0 9d 00000000 4 1 00
0c 3 11223300 0 bd 0 00 00000000 3 1 00
07 2 ffff0000 0 db 1 55 cafef00d 0 0 00
01 1 0a000000 0 81 0 00 00000000 0 0 0a
10 1 01000000 1 00 0 00 00000000 0 0 01
